/* source/cnn_cfg_pkg.sv */
// ==========================================================================
// CNN core configuration
// sizes and datapath widths of the single conv and pool stage
// ==========================================================================
package cnn_cfg_pkg;

    localparam int IMG_DIM   = 4;     // image side in pixels
    localparam int N_MAPS    = 2;     // kernels and output maps
    localparam int K_DIM     = 3;     // kernel side
    localparam int K_TAPS    = 9;     // taps per kernel
    localparam int N_PIX     = 16;    // image pixel count
    localparam int N_WEIGHTS = 18;    // all kernels together
    localparam int N_CONV    = 32;    // conv results over both maps
    localparam int N_OUT     = 8;     // pooled words per frame
    localparam int PIX_W     = 16;    // pixel, weight and bias width
    localparam int ACC_W     = 32;    // accumulator and output width

endpackage

/* source/cnn_types_pkg.sv */
// ==========================================================================
// CNN core types
// datapath vectors, index widths and the controller phases
// ==========================================================================
package cnn_types_pkg;

    typedef logic signed [cnn_cfg_pkg::PIX_W-1:0] pixel_t;   // pixel, weight, bias
    typedef logic signed [cnn_cfg_pkg::ACC_W-1:0] acc_t;     // products, sums, results

    typedef logic [$clog2(cnn_cfg_pkg::N_WEIGHTS)-1:0] word_idx_t;  // load word index
    typedef logic [$clog2(cnn_cfg_pkg::N_CONV)-1:0]    conv_idx_t;  // conv buffer index

    typedef enum logic [2:0] {
        IDLE,
        LOAD_PIC,
        LOAD_BIAS,
        LOAD_WEIGHT,
        CONV,
        POOL,
        DONE
    } ctrl_state_t;

endpackage

/* source/layer_ctrl.sv */
// ==========================================================================
// Layer controller
// walks the load, conv and pool phases of one frame, owns the
// input stream read strobe and counts the words of each load phase
// ==========================================================================
module layer_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     isif_empty_n,
    input  logic                     conv_done,
    input  logic                     pool_done,
    output logic                     isif_read,
    output logic                     load_pic_en,
    output logic                     load_bias_en,
    output logic                     load_weight_en,
    output cnn_types_pkg::word_idx_t word_idx,
    output logic                     conv_start,
    output logic                     pool_start
);
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    ctrl_state_t state;
    word_idx_t   phase_words;   // word count of the current load phase
    logic        load_phase;
    logic        phase_end;     // last word of the phase is read now

    always_comb begin
        case (state)
            LOAD_PIC:    phase_words = word_idx_t'(N_PIX);
            LOAD_BIAS:   phase_words = word_idx_t'(N_MAPS);
            LOAD_WEIGHT: phase_words = word_idx_t'(N_WEIGHTS);
            default:     phase_words = '0;
        endcase
    end

    assign load_phase = (state == LOAD_PIC) || (state == LOAD_BIAS) ||
                        (state == LOAD_WEIGHT);
    assign isif_read  = load_phase && isif_empty_n;   // stalls only stretch a phase
    assign phase_end  = isif_read && (word_idx == phase_words - 1'b1);

    assign load_pic_en    = isif_read && (state == LOAD_PIC);
    assign load_bias_en   = isif_read && (state == LOAD_BIAS);
    assign load_weight_en = isif_read && (state == LOAD_WEIGHT);

    // ======================================================================
    // phase FSM
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            word_idx   <= '0;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
        end else begin
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            if (isif_read) begin
                word_idx <= phase_end ? '0 : word_idx + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (isif_empty_n) begin
                        state <= LOAD_PIC;
                    end
                end
                LOAD_PIC: begin
                    if (phase_end) begin
                        state <= LOAD_BIAS;
                    end
                end
                LOAD_BIAS: begin
                    if (phase_end) begin
                        state <= LOAD_WEIGHT;
                    end
                end
                LOAD_WEIGHT: begin
                    if (phase_end) begin
                        state      <= CONV;
                        conv_start <= 1'b1;   // one cycle pulse
                    end
                end
                CONV: begin
                    if (conv_done) begin
                        state      <= POOL;
                        pool_start <= 1'b1;
                    end
                end
                POOL: begin
                    if (pool_done) begin
                        state <= DONE;   // last word written
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/param_store.sv */
// ==========================================================================
// Parameter store
// bias and weight register file, filled in load order from the input
// stream and read by index with one cycle of latency
// ==========================================================================
module param_store (
    input  logic                                    clk,
    input  logic                                    rst,
    input  cnn_types_pkg::pixel_t                   isif_data,
    input  logic                                    load_bias_en,
    input  logic                                    load_weight_en,
    input  cnn_types_pkg::word_idx_t                word_idx,
    input  cnn_types_pkg::word_idx_t                weight_idx,
    input  logic [$clog2(cnn_cfg_pkg::N_MAPS)-1:0]  bias_idx,
    output cnn_types_pkg::pixel_t                   weight,
    output cnn_types_pkg::pixel_t                   bias
);
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    pixel_t bias_mem   [N_MAPS];
    pixel_t weight_mem [N_WEIGHTS];

    always_ff @(posedge clk) begin
        if (load_bias_en) begin
            bias_mem[word_idx[$clog2(N_MAPS)-1:0]] <= isif_data;
        end
        if (load_weight_en) begin
            weight_mem[word_idx] <= isif_data;   // map 0 taps, then map 1
        end
    end

    // read stage lines up with the engine's pixel register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weight <= '0;
            bias   <= '0;
        end else begin
            weight <= weight_mem[weight_idx];
            bias   <= bias_mem[bias_idx];
        end
    end

endmodule

/* source/conv_engine.sv */
// ==========================================================================
// Convolution engine
// holds the image, scans map, row, column and tap over a zero padded
// window and accumulates the products in a two stage pipeline, adding
// the bias and applying ReLU as each result is written out
// ==========================================================================
module conv_engine (
    input  logic                                    clk,
    input  logic                                    rst,
    input  cnn_types_pkg::pixel_t                   isif_data,
    input  logic                                    load_pic_en,
    input  cnn_types_pkg::word_idx_t                word_idx,
    input  logic                                    conv_start,
    input  cnn_types_pkg::pixel_t                   weight,
    input  cnn_types_pkg::pixel_t                   bias,
    output cnn_types_pkg::word_idx_t                weight_idx,
    output logic [$clog2(cnn_cfg_pkg::N_MAPS)-1:0]  bias_idx,
    output logic                                    conv_wr,
    output cnn_types_pkg::conv_idx_t                conv_addr,
    output cnn_types_pkg::acc_t                     conv_data,
    output logic                                    conv_done
);
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    pixel_t img [N_PIX];

    logic                       busy;
    logic [$clog2(N_MAPS)-1:0]  map_cnt;
    logic [1:0]                 row_cnt, col_cnt;   // output position
    logic [1:0]                 kx, ky;             // tap inside the kernel
    logic                       tap_first, tap_last, scan_last;
    logic [2:0]                 py, px;             // position in the padded image
    logic [2:0]                 iy, ix;
    logic [3:0]                 img_addr;
    logic                       pad;

    logic                       v1, first1, last1, end1;   // read stage
    conv_idx_t                  addr1;
    pixel_t                     pix_q;
    acc_t                       acc, prod, sum, biased;    // mac stage

    always_ff @(posedge clk) begin
        if (load_pic_en) begin
            img[word_idx[$clog2(N_PIX)-1:0]] <= isif_data;   // row major
        end
    end

    // ======================================================================
    // window scan
    // ======================================================================
    assign tap_first = (kx == 2'd0) && (ky == 2'd0);
    assign tap_last  = (kx == 2'(K_DIM - 1)) && (ky == 2'(K_DIM - 1));
    assign scan_last = tap_last && (col_cnt == 2'(IMG_DIM - 1)) &&
                       (row_cnt == 2'(IMG_DIM - 1)) && (map_cnt == 1'(N_MAPS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            map_cnt <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            kx      <= '0;
            ky      <= '0;
        end else if (conv_start) begin
            busy <= 1'b1;
        end else if (busy) begin
            busy <= !scan_last;   // all counters wrap back to zero
            kx   <= (kx == 2'(K_DIM - 1)) ? 2'd0 : kx + 2'd1;
            if (kx == 2'(K_DIM - 1)) begin
                ky <= (ky == 2'(K_DIM - 1)) ? 2'd0 : ky + 2'd1;
            end
            if (tap_last) begin
                col_cnt <= col_cnt + 2'd1;
                if (col_cnt == 2'(IMG_DIM - 1)) begin
                    row_cnt <= row_cnt + 2'd1;
                    if (row_cnt == 2'(IMG_DIM - 1)) begin
                        map_cnt <= map_cnt + 1'b1;
                    end
                end
            end
        end
    end

    assign py       = {1'b0, row_cnt} + {1'b0, ky};
    assign px       = {1'b0, col_cnt} + {1'b0, kx};
    assign iy       = py - 3'd1;
    assign ix       = px - 3'd1;
    assign pad      = (py == 3'd0) || (py > 3'(IMG_DIM)) || (px == 3'd0) || (px > 3'(IMG_DIM));
    assign img_addr = {iy[1:0], ix[1:0]};

    assign weight_idx = word_idx_t'(int'(map_cnt) * K_TAPS + int'(ky) * K_DIM + int'(kx));
    assign bias_idx   = map_cnt;

    // ======================================================================
    // read stage, then multiply accumulate
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v1     <= 1'b0;
            first1 <= 1'b0;
            last1  <= 1'b0;
            end1   <= 1'b0;
        end else begin
            v1     <= busy;
            first1 <= tap_first;
            last1  <= tap_last;
            end1   <= busy && scan_last;
        end
    end

    always_ff @(posedge clk) begin
        addr1 <= {map_cnt, row_cnt, col_cnt};    // map*16 + row*4 + col
        pix_q <= pad ? pixel_t'(0) : img[img_addr];
    end

    assign prod   = pix_q * weight;
    assign sum    = (first1 ? acc_t'(0) : acc) + prod;   // first tap restarts the sum
    assign biased = sum + acc_t'(bias);

    always_ff @(posedge clk) begin
        if (v1) begin
            acc <= sum;
        end
    end

    assign conv_wr   = v1 && last1;
    assign conv_addr = addr1;
    assign conv_data = biased[ACC_W-1] ? acc_t'(0) : biased;   // ReLU

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            conv_done <= 1'b0;
        end else begin
            conv_done <= v1 && end1;   // right after the last write
        end
    end

endmodule

/* source/pool_unit.sv */
// ==========================================================================
// Pooling unit
// stores the conv results, runs a 2x2 stride 2 max-pool over each map
// and writes the pooled words to the output stream under back-pressure
// ==========================================================================
module pool_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     conv_wr,
    input  cnn_types_pkg::conv_idx_t conv_addr,
    input  cnn_types_pkg::acc_t      conv_data,
    input  logic                     pool_start,
    input  logic                     osif_full_n,
    output cnn_types_pkg::acc_t      osif_data,
    output logic                     osif_last,
    output logic                     osif_write,
    output logic                     pool_done
);
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    acc_t conv_buf [N_CONV];

    logic                      busy, stall;
    logic [$clog2(N_OUT)-1:0]  win_cnt;   // map, pool row, pool col
    logic [1:0]                q_cnt;     // dy, dx inside the window
    conv_idx_t                 rd_addr;
    logic                      rd_v, rd_first, rd_last, rd_end;
    acc_t                      rd_data, run_max, win_max, out_data;
    logic                      out_valid, out_last;

    always_ff @(posedge clk) begin
        if (conv_wr) begin
            conv_buf[conv_addr] <= conv_data;
        end
    end

    assign rd_addr = {win_cnt[2], win_cnt[1], q_cnt[1], win_cnt[0], q_cnt[0]};
    assign stall   = out_valid && !osif_full_n;   // held word not taken yet

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            win_cnt <= '0;
            q_cnt   <= '0;
        end else if (pool_start) begin
            busy <= 1'b1;
        end else if (busy && !stall) begin
            q_cnt <= q_cnt + 2'd1;
            if (q_cnt == 2'd3) begin
                win_cnt <= win_cnt + 1'b1;
                busy    <= (win_cnt != 3'(N_OUT - 1));
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_v     <= 1'b0;
            rd_first <= 1'b0;
            rd_last  <= 1'b0;
            rd_end   <= 1'b0;
        end else if (!stall) begin
            rd_v     <= busy;
            rd_first <= (q_cnt == 2'd0);
            rd_last  <= (q_cnt == 2'd3);
            rd_end   <= (win_cnt == 3'(N_OUT - 1));
        end
    end

    assign win_max = (rd_first || (rd_data > run_max)) ? rd_data : run_max;

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_data <= conv_buf[rd_addr];
        end
        if (rd_v && !stall) begin
            run_max <= win_max;
        end
        if (rd_v && rd_last && !stall) begin
            out_data <= win_max;   // max of all four
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (rd_v && rd_last && !stall) begin
            out_valid <= 1'b1;
            out_last  <= rd_end;
        end else if (osif_write) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    assign osif_write = out_valid && osif_full_n;
    assign osif_last  = osif_write && out_last;
    assign osif_data  = out_data;
    assign pool_done  = osif_last;   // frame ends with the flagged word

endmodule

/* source/cnn_core.sv */
// ==========================================================================
// CNN core top level
// one 3x3 conv layer with bias, ReLU and 2x2 max-pool between an input
// FIFO stream and an output FIFO stream
// ==========================================================================
module cnn_core (
    input  logic                  clk,
    input  logic                  rst,
    input  cnn_types_pkg::pixel_t isif_data,
    input  logic                  isif_empty_n,
    output logic                  isif_read,
    output cnn_types_pkg::acc_t   osif_data,
    output logic                  osif_last,
    input  logic                  osif_full_n,
    output logic                  osif_write
);
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    logic                       load_pic_en, load_bias_en, load_weight_en;
    word_idx_t                  word_idx, weight_idx;
    logic [$clog2(N_MAPS)-1:0]  bias_idx;
    pixel_t                     weight, bias;
    logic                       conv_start, conv_done, pool_start, pool_done;
    logic                       conv_wr;
    conv_idx_t                  conv_addr;
    acc_t                       conv_data;

    layer_ctrl ctrl_i (
        .clk, .rst, .isif_empty_n, .conv_done, .pool_done, .isif_read,
        .load_pic_en, .load_bias_en, .load_weight_en, .word_idx, .conv_start, .pool_start
    );

    param_store param_i (
        .clk, .rst, .isif_data, .load_bias_en, .load_weight_en, .word_idx,
        .weight_idx, .bias_idx, .weight, .bias
    );

    conv_engine conv_i (
        .clk, .rst, .isif_data, .load_pic_en, .word_idx, .conv_start, .weight, .bias,
        .weight_idx, .bias_idx, .conv_wr, .conv_addr, .conv_data, .conv_done
    );

    pool_unit pool_i (
        .clk, .rst, .conv_wr, .conv_addr, .conv_data, .pool_start, .osif_full_n,
        .osif_data, .osif_last, .osif_write, .pool_done
    );

endmodule

/* verification/cnn_core_chk.sv */
// ==========================================================================
// CNN core stream checker
// concurrent assertions on the FIFO stream strobes, bound into the core
// ==========================================================================
module cnn_core_chk (
    input logic clk,
    input logic rst,
    input logic isif_empty_n,
    input logic isif_read,
    input logic osif_full_n,
    input logic osif_write,
    input logic osif_last
);

    // strobes low in the cycle after any reset cycle
    reset_quiet_a: assert property (@(posedge clk)
        rst |=> !isif_read && !osif_write && !osif_last)
        else $error("stream strobe active after a reset cycle");

    read_needs_data_a: assert property (@(posedge clk) disable iff (rst)
        isif_read |-> isif_empty_n)
        else $error("isif_read while the input stream is empty");

    write_needs_room_a: assert property (@(posedge clk) disable iff (rst)
        osif_write |-> osif_full_n)
        else $error("osif_write while the output stream is full");

endmodule

bind cnn_core cnn_core_chk chk_i (
    .clk, .rst, .isif_empty_n, .isif_read, .osif_full_n, .osif_write, .osif_last
);

/* verification/cnn_core_tb.sv */
// ==========================================================================
// CNN core testbench
// serves a frame from the stimulus file over the input stream, collects
// the pooled words and compares them with the expected values, once
// without and once with random stalls on both streams
// ==========================================================================
module cnn_core_tb;
    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_IN       = N_PIX + N_MAPS + N_WEIGHTS;   // words per frame
    localparam int STIM_W     = $clog2(N_IN + N_OUT);
    localparam int N_FRAMES   = 2;
    localparam int FRAME_CYC  = N_IN + N_CONV * K_TAPS + N_CONV * 4 + N_OUT;
    localparam int WDOG_CYC   = 4 * N_FRAMES * FRAME_CYC;

    logic   clk = 1'b0;
    logic   rst;
    pixel_t isif_data;
    logic   isif_empty_n;
    logic   isif_read;
    acc_t   osif_data;
    logic   osif_last;
    logic   osif_full_n;
    logic   osif_write;

    logic [31:0] stim_mem [N_IN + N_OUT];   // input words, then expected outputs
    int in_ptr;    // next word served, N_IN once the frame is used up
    int out_cnt;   // words collected in the current frame
    int errors, data_err, last_err, late_err, stream_err;
    int tests_run, tests_failed;
    int seed;
    bit rand_stall, in_gap, out_gap;

    cnn_core dut_i (
        .clk, .rst, .isif_data, .isif_empty_n, .isif_read,
        .osif_data, .osif_last, .osif_full_n, .osif_write
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // checks and reporting
    // ======================================================================
    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
            data_err++;
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
            last_err++;
        end
    endtask

    task automatic stream_error(input string what);
        $display("ERROR: %s (word %0d in, word %0d out)", what, in_ptr, out_cnt);
        errors++;
    endtask

    task automatic check_idle_strobes();
        check_last("isif_read", isif_read, 1'b0);
        check_last("osif_write", osif_write, 1'b0);
        check_last("osif_last", osif_last, 1'b0);
    endtask

    task automatic report_test(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s failed with %0d errors", name, fails);
        end
    endtask

    // ======================================================================
    // input FIFO model and output collector
    // ======================================================================
    always @(negedge clk) begin
        in_gap  = rand_stall && (($random(seed) & 1) == 0);
        out_gap = rand_stall && (($random(seed) & 1) == 0);
        isif_empty_n = (in_ptr < N_IN) && !in_gap;
        isif_data    = (in_ptr < N_IN) ? pixel_t'(stim_mem[STIM_W'(in_ptr)][15:0]) : '0;
        osif_full_n  = !out_gap;
        #(CLK_PERIOD / 10);   // strobes settled, taken at the next rising edge
        if (isif_read && !isif_empty_n) begin
            stream_err++;
            stream_error("isif_read while the input stream is empty");
        end else if (isif_read) begin
            in_ptr++;
        end
        if (osif_write && !osif_full_n) begin
            stream_err++;
            stream_error("osif_write while the output stream is full");
        end
        if (osif_last && !osif_write) begin
            stream_err++;
            stream_error("osif_last raised without a write");
        end
        if (osif_write && out_cnt >= N_OUT) begin
            late_err++;
            stream_error("output write after the last word of the frame");
        end else if (osif_write) begin
            check_acc("osif_data", osif_data, acc_t'(stim_mem[STIM_W'(N_IN + out_cnt)]));
            check_last("osif_last", osif_last, out_cnt == N_OUT - 1);
        end
        if (osif_write) begin
            out_cnt++;
        end
    end

    task automatic run_frame(input bit stalls);
        @(posedge clk);
        rand_stall = stalls;
        out_cnt    = 0;
        in_ptr     = 0;   // frame becomes available
        wait (out_cnt >= N_OUT);
        repeat (20) @(posedge clk);   // quiet window after the flagged word
        if (in_ptr != N_IN) begin
            stream_err++;
            stream_error($sformatf("consumed %0d input words instead of %0d", in_ptr, N_IN));
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int mark_err, mark_data, mark_last;
        rst          = 1'b1;
        isif_data    = '0;
        isif_empty_n = 1'b0;
        osif_full_n  = 1'b1;
        in_ptr       = N_IN;
        out_cnt      = 0;
        errors       = 0;
        data_err     = 0;
        last_err     = 0;
        late_err     = 0;
        stream_err   = 0;
        tests_run    = 0;
        tests_failed = 0;
        rand_stall   = 1'b0;
        seed         = 32'h9030ab9c;
        $readmemh("verification/cnn_stim.hex", stim_mem);

        mark_err = errors;
        repeat (4) begin
            @(negedge clk);
            #(CLK_PERIOD / 5);
            check_idle_strobes();
        end
        @(negedge clk);
        rst = 1'b0;   // five rising edges seen in reset
        repeat (2) begin
            #(CLK_PERIOD / 5);
            check_idle_strobes();
            @(negedge clk);
        end
        report_test("reset_state", errors - mark_err);

        mark_data = data_err;
        mark_last = last_err + late_err;
        run_frame(1'b0);
        report_test("full_frame", data_err - mark_data);
        report_test("frame_end", last_err + late_err - mark_last);

        mark_err = errors;
        run_frame(1'b1);
        report_test("stalls", errors - mark_err);
        report_test("exact_consumption", stream_err);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, frames did not finish", WDOG_CYC);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verification/cnn_stim.hex */
// input words, 16-bit two's complement: 16 pixels row major, 2 biases, 18 weights
// then 8 expected pooled outputs, 32-bit, in map, row, column order
// image rows
0001 FFFE 0003 0004
0005 0006 FFF9 0008
FFF7 000A 000B 000C
000D 000E 000F FFF0
// biases of map 0 and map 1
FFEC
0005
// kernel of map 0, rows ky 0 to 2, columns kx 0 to 2
0001 0001 0001
0001 0001 0001
0002 0001 0001
// kernel of map 1
0000 0000 0001
0000 0003 0000
0000 0000 FFFE
// expected outputs of map 0
00000000
00000023
00000033
0000002F
// expected outputs of map 1
0000000D
0000001D
0000003A
0000004E

/* tb.f */
source/cnn_cfg_pkg.sv
source/cnn_types_pkg.sv
source/layer_ctrl.sv
source/param_store.sv
source/conv_engine.sv
source/pool_unit.sv
source/cnn_core.sv
verification/cnn_core_chk.sv
verification/cnn_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the cnn_core testbench, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cnn_core_tb -f tb.f \
    -o cnn_core_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cnn_core_sim +verilator+error+limit+100 > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "FAIL, no verdict in sim.log"; exit 1; }
echo "PASS"
